//--- panel_consts.svh
// board control constants
// frame layout, register map and reset values of the control block
`ifndef PANEL_CONSTS_SVH
`define PANEL_CONSTS_SVH

////////////////////////////////////////
// spi frame layout

// full frame, address byte then value byte
`define SPI_FRAME_BITS 16
`define SPI_ADDR_BITS 8
`define SPI_VALUE_BITS (`SPI_FRAME_BITS - `SPI_ADDR_BITS)

// sampled bit counter, saturates at all ones
`define SPI_CNT_BITS 5

////////////////////////////////////////
// control registers

`define CTRL_NIB_BITS 4
`define CHIP_SEL_LINES 8

// register map
`define ADDR_POWERUP 8'd6
`define ADDR_LED 8'd7
`define ADDR_SPI_MUX 8'd8
`define ADDR_DAC 8'd9
`define ADDR_SOFT_RST 8'd11
`define ADDR_ADC 8'd14

// dac control lines idle high after reset
`define DAC_RESET_VAL 4'b1111

`endif

//--- panel_pkg.sv
// board control types
// frame, register file and strobe bundles shared by the spi control block
package panel_pkg;

  `include "panel_consts.svh"

  ////////////////////////////////////////
  // received frame

  // addr is the first byte on the wire, so it sits in the msbs
  typedef struct packed {
    logic [`SPI_ADDR_BITS-1:0]  addr;
    logic [`SPI_VALUE_BITS-1:0] value;
  } spi_frame_t;

  ////////////////////////////////////////
  // register file

  // led, dac and adc use set/clear/toggle
  // spi_mux is a one-hot peripheral select
  typedef struct packed {
    logic [`CTRL_NIB_BITS-1:0]  led;
    logic [`CHIP_SEL_LINES-1:0] spi_mux;
    logic [`CTRL_NIB_BITS-1:0]  dac;
    logic [`CTRL_NIB_BITS-1:0]  adc;
  } ctrl_regs_t;

  ////////////////////////////////////////
  // frame strobes

  // single clk pulses from the frame fsm
  // start on cs_n fall
  // sample on sclk rise, drive on sclk fall
  // commit on cs_n rise after a full frame
  typedef struct packed {
    logic start;
    logic sample;
    logic drive;
    logic commit;
  } spi_strobe_t;

endpackage

//--- spi_frame_fsm.sv
// spi frame control
// synchronizes the spi pins into clk, detects sclk and cs_n edges
// and steps each frame through idle, shift, commit or discard
`timescale 1ns/1ps

module spi_frame_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    frame_full,
  output panel_pkg::spi_strobe_t  strobe,
  output logic                    mosi_sync
);

  import panel_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_COMMIT,
    ST_DISCARD
  } frame_state_t;

  frame_state_t state_q;
  frame_state_t state_d;
  spi_strobe_t  strobe_d;

  // two sync stages plus one history stage per pin
  logic [2:0] sclk_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_fall;
  logic cs_rise;

  ////////////////////////////////////////
  // pin synchronizers

  // sclk idles low in mode 0, cs_n idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_q    <= 3'b000;
      cs_q      <= 3'b111;
      mosi_q    <= 2'b00;
      mosi_sync <= 1'b0;
    end
    else
    begin
      sclk_q    <= {sclk_q[1:0], sclk};
      cs_q      <= {cs_q[1:0], cs_n};
      mosi_q    <= {mosi_q[0], mosi};
      // extra stage lines mosi up with the registered strobes
      mosi_sync <= mosi_q[1];
    end
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];

  ////////////////////////////////////////
  // frame state machine

  always_comb
  begin
    state_d  = state_q;
    strobe_d = '0;
    case (state_q)
      ST_SHIFT:
      begin
        if (cs_rise)
        begin
          // only an exact 16 bit frame reaches the registers
          if (frame_full)
          begin
            state_d         = ST_COMMIT;
            strobe_d.commit = 1'b1;
          end
          else
            state_d = ST_DISCARD;
        end
        else
        begin
          strobe_d.sample = sclk_rise;
          strobe_d.drive  = sclk_fall;
        end
      end
      default:
      begin
        // idle, commit and discard all wait for the next cs_n fall
        if (cs_fall)
        begin
          state_d        = ST_SHIFT;
          strobe_d.start = 1'b1;
        end
        else
          state_d = ST_IDLE;
      end
    endcase
  end

  // strobes registered, pin edge to strobe is 3 clk
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_IDLE;
      strobe  <= '0;
    end
    else
    begin
      state_q <= state_d;
      strobe  <= strobe_d;
    end
  end

endmodule

//--- spi_bit_counter.sv
// spi bit counter
// counts sampled bits of a frame, flags the address boundary and a full frame
`timescale 1ns/1ps

`include "panel_consts.svh"

module spi_bit_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  panel_pkg::spi_strobe_t  strobe,
  output logic                    addr_done,
  output logic                    frame_full
);

  logic [`SPI_CNT_BITS-1:0] bit_cnt;

  // restart on cs_n fall
  // holds at all ones so long frames never wrap back to 16
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (strobe.start)
      bit_cnt <= '0;
    else if (strobe.sample && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // address byte complete
  assign addr_done  = (bit_cnt == `SPI_CNT_BITS'(`SPI_ADDR_BITS));
  // exactly one frame of bits seen
  assign frame_full = (bit_cnt == `SPI_CNT_BITS'(`SPI_FRAME_BITS));

endmodule

//--- spi_shifter.sv
// spi data shifter
// shifts mosi into the frame register and the readback byte out on dout
`timescale 1ns/1ps

`include "panel_consts.svh"

module spi_shifter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  panel_pkg::spi_strobe_t      strobe,
  input  logic                        mosi_sync,
  input  logic                        addr_done,
  input  logic [`SPI_VALUE_BITS-1:0]  rd_data,
  output panel_pkg::spi_frame_t       frame,
  output logic                        dout
);

  logic [`SPI_FRAME_BITS-1:0] shift_in;
  logic [`SPI_VALUE_BITS-1:0] shift_out;

  ////////////////////////////////////////
  // receive side

  // msb first, newest bit lands in bit 0
  always_ff @(posedge clk)
  begin
    if (strobe.sample)
      shift_in <= {shift_in[`SPI_FRAME_BITS-2:0], mosi_sync};
  end

  // at the address boundary only 8 bits are in, so the address
  // is still in the low byte
  // a full frame has it in the high byte
  always_comb
  begin
    frame.value = shift_in[`SPI_VALUE_BITS-1:0];
    if (addr_done)
      frame.addr = shift_in[`SPI_ADDR_BITS-1:0];
    else
      frame.addr = shift_in[`SPI_FRAME_BITS-1:`SPI_VALUE_BITS];
  end

  ////////////////////////////////////////
  // transmit side

  // load on the sclk fall after the address byte
  // zero fill, so dout drops to 0 once the read byte is out
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      shift_out <= '0;
    else if (strobe.start || strobe.commit)
      shift_out <= '0;
    else if (strobe.drive)
    begin
      if (addr_done)
        shift_out <= rd_data;
      else
        shift_out <= {shift_out[`SPI_VALUE_BITS-2:0], 1'b0};
    end
  end

  // mode 0, host samples this on the next sclk rise
  assign dout = shift_out[`SPI_VALUE_BITS-1];

endmodule

//--- ctrl_reg_bank.sv
// control register bank
// applies committed frames to led, spi_mux, dac and adc
// and decodes the readback byte from the frame address
`timescale 1ns/1ps

`include "panel_consts.svh"

module ctrl_reg_bank (
  input  logic                        clk,
  input  logic                        rst_n,
  input  panel_pkg::spi_strobe_t      strobe,
  input  panel_pkg::spi_frame_t       frame,
  output panel_pkg::ctrl_regs_t       regs,
  output logic [`SPI_VALUE_BITS-1:0]  rd_data
);

  ////////////////////////////////////////
  // write rules

  // low nibble sets, high nibble clears
  // bits named in both nibbles toggle, and then nothing else changes
  function automatic logic [`CTRL_NIB_BITS-1:0] nib_update(
    input logic [`CTRL_NIB_BITS-1:0]  cur,
    input logic [`SPI_VALUE_BITS-1:0] value
  );
    logic [`CTRL_NIB_BITS-1:0] set_bits;
    logic [`CTRL_NIB_BITS-1:0] clr_bits;
    logic [`CTRL_NIB_BITS-1:0] tgl_bits;
    set_bits = value[`CTRL_NIB_BITS-1:0];
    clr_bits = value[2*`CTRL_NIB_BITS-1:`CTRL_NIB_BITS];
    tgl_bits = set_bits & clr_bits;
    if (tgl_bits != '0)
      nib_update = cur ^ tgl_bits;
    else
      nib_update = (cur | set_bits) & ~clr_bits;
  endfunction

  // value n picks line n-1
  // 0 or out of range deselects everything
  function automatic logic [`CHIP_SEL_LINES-1:0] one_hot_sel(
    input logic [`SPI_VALUE_BITS-1:0] value
  );
    if (value == '0 || value > `SPI_VALUE_BITS'(`CHIP_SEL_LINES))
      one_hot_sel = '0;
    else
      one_hot_sel = `CHIP_SEL_LINES'(1) << (value - 1'b1);
  endfunction

  ////////////////////////////////////////
  // registers

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      regs.led     <= '0;
      regs.spi_mux <= '0;
      regs.dac     <= `DAC_RESET_VAL;
      regs.adc     <= '0;
    end
    else if (strobe.commit)
    begin
      case (frame.addr)
        `ADDR_LED:     regs.led     <= nib_update(regs.led, frame.value);
        `ADDR_SPI_MUX: regs.spi_mux <= one_hot_sel(frame.value);
        `ADDR_DAC:     regs.dac     <= nib_update(regs.dac, frame.value);
        `ADDR_ADC:     regs.adc     <= nib_update(regs.adc, frame.value);
        // soft reset, everything to zero including dac
        `ADDR_SOFT_RST:
        begin
          regs.led     <= '0;
          regs.spi_mux <= '0;
          regs.dac     <= '0;
          regs.adc     <= '0;
        end
        // power-up, dac and mux already set up, leave them
        `ADDR_POWERUP:
        begin
          regs.led <= '0;
          regs.adc <= '0;
        end
        // unknown address, no change
        default:
        begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // readback

  // adc has no readback
  always_comb
  begin
    case (frame.addr)
      `ADDR_LED:     rd_data = `SPI_VALUE_BITS'(regs.led);
      `ADDR_SPI_MUX: rd_data = `SPI_VALUE_BITS'(regs.spi_mux);
      `ADDR_DAC:     rd_data = `SPI_VALUE_BITS'(regs.dac);
      default:       rd_data = '0;
    endcase
  end

endmodule

//--- periph_spi_mux.sv
// peripheral spi switch
// with cs2_n low the selected peripheral gets the chip select and drives miso
// with cs2_n high miso carries the register bank readback
`timescale 1ns/1ps

`include "panel_consts.svh"

module periph_spi_mux (
  input  logic                        cs2_n,
  input  logic [`CHIP_SEL_LINES-1:0]  spi_mux,
  input  logic                        dout,
  input  logic [`CHIP_SEL_LINES-1:0]  periph_miso,
  output logic [`CHIP_SEL_LINES-1:0]  periph_cs_n,
  output logic                        miso
);

  logic [`CHIP_SEL_LINES-1:0] miso_hit;

  // only the selected line can pass its miso
  assign miso_hit = spi_mux & periph_miso;

  always_comb
  begin
    if (cs2_n)
    begin
      // pass-through idle, all peripherals deselected
      periph_cs_n = '1;
      miso        = dout;
    end
    else
    begin
      // active low selects follow cs2_n
      periph_cs_n = ~spi_mux;
      // nothing selected reads as 0
      miso        = |miso_hit;
    end
  end

endmodule

//--- panel_top.sv
// board control top
// spi register interface on cs_n plus a peripheral spi switch on cs2_n
`timescale 1ns/1ps

`include "panel_consts.svh"

module panel_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        sclk,
  input  logic                        cs_n,
  input  logic                        mosi,
  input  logic                        cs2_n,
  input  logic [`CHIP_SEL_LINES-1:0]  periph_miso,
  output logic                        miso,
  output logic [`CHIP_SEL_LINES-1:0]  periph_cs_n,
  output logic                        periph_sclk,
  output logic                        periph_mosi,
  output logic [`CTRL_NIB_BITS-1:0]   led,
  output logic [`CTRL_NIB_BITS-1:0]   dac_ctrl,
  output logic [`CTRL_NIB_BITS-1:0]   adc_ctrl
);

  import panel_pkg::*;

  spi_strobe_t                strobe;
  spi_frame_t                 frame;
  ctrl_regs_t                 regs;
  logic                       mosi_sync;
  logic                       addr_done;
  logic                       frame_full;
  logic                       dout;
  logic [`SPI_VALUE_BITS-1:0] rd_data;

  ////////////////////////////////////////
  // register interface

  spi_frame_fsm u_frame_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .frame_full (frame_full),
    .strobe     (strobe),
    .mosi_sync  (mosi_sync)
  );

  spi_bit_counter u_bit_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .strobe     (strobe),
    .addr_done  (addr_done),
    .frame_full (frame_full)
  );

  spi_shifter u_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .strobe     (strobe),
    .mosi_sync  (mosi_sync),
    .addr_done  (addr_done),
    .rd_data    (rd_data),
    .frame      (frame),
    .dout       (dout)
  );

  ctrl_reg_bank u_reg_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .strobe     (strobe),
    .frame      (frame),
    .regs       (regs),
    .rd_data    (rd_data)
  );

  ////////////////////////////////////////
  // peripheral switch

  periph_spi_mux u_periph_mux (
    .cs2_n       (cs2_n),
    .spi_mux     (regs.spi_mux),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  // clock and data fan straight out to every peripheral
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  // board control lines
  assign led      = regs.led;
  assign dac_ctrl = regs.dac;
  assign adc_ctrl = regs.adc;

endmodule

//--- tb_panel_top.sv
// board control testbench
// spi host, register model and checks for the panel control block
`timescale 1ns/1ps

`include "panel_consts.svh"

module tb_panel_top;

  // sclk half period in clk cycles
  localparam int HALF_SCLK  = 10;
  // frames sent by the test sequence
  localparam int NUM_FRAMES = 54;
  // cs_n rise to register update is 4 clk, wait a bit more
  localparam int SETTLE     = 8;
  // frames x 17 bits x 20 clk x 10 ns, plus 2 us
  localparam int WATCHDOG_NS = NUM_FRAMES * 17 * 20 * 10 + 2000;

  logic                       clk;
  logic                       rst_n;
  logic                       sclk;
  logic                       cs_n;
  logic                       mosi;
  logic                       cs2_n;
  logic [`CHIP_SEL_LINES-1:0] periph_miso;
  logic                       miso;
  logic [`CHIP_SEL_LINES-1:0] periph_cs_n;
  logic                       periph_sclk;
  logic                       periph_mosi;
  logic [`CTRL_NIB_BITS-1:0]  led;
  logic [`CTRL_NIB_BITS-1:0]  dac_ctrl;
  logic [`CTRL_NIB_BITS-1:0]  adc_ctrl;

  // register model
  logic [3:0] m_led;
  logic [7:0] m_mux;
  logic [3:0] m_dac;
  logic [3:0] m_adc;

  integer seed = 32'hdd929cd9;

  panel_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .adc_ctrl    (adc_ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // reporting

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else
      stop_on_failure($sformatf("[ERROR] t=%0t %s got 0x%02h expected 0x%02h",
                                $time, name, got, exp));
  endtask

  // hang guard
  initial
  begin
    #(WATCHDOG_NS);
    stop_on_failure("watchdog expired before the tests finished");
  end

  ////////////////////////////////////////
  // reference model

  // set/clear, overlapping bits toggle only
  function automatic logic [3:0] apply_sct(input logic [3:0] cur, input logic [7:0] v);
    logic [3:0] both;
    both = v[3:0] & v[7:4];
    if (both != 4'h0)
      return cur ^ both;
    return (cur & ~v[7:4]) | v[3:0];
  endfunction

  // n selects line n-1
  function automatic logic [7:0] select_line(input logic [7:0] v);
    logic [7:0] sel;
    int         k;
    sel = 8'h00;
    for (k = 0; k < 8; k++)
      sel[k] = (v == 8'(k + 1));
    return sel;
  endfunction

  function automatic logic [7:0] model_readback(input logic [7:0] addr);
    case (addr)
      `ADDR_LED:     return {4'h0, m_led};
      `ADDR_SPI_MUX: return m_mux;
      `ADDR_DAC:     return {4'h0, m_dac};
      default:       return 8'h00;
    endcase
  endfunction

  task automatic model_commit(input logic [7:0] addr, input logic [7:0] value);
    case (addr)
      `ADDR_LED:     m_led = apply_sct(m_led, value);
      `ADDR_SPI_MUX: m_mux = select_line(value);
      `ADDR_DAC:     m_dac = apply_sct(m_dac, value);
      `ADDR_ADC:     m_adc = apply_sct(m_adc, value);
      `ADDR_SOFT_RST:
      begin
        m_led = 4'h0;
        m_mux = 8'h00;
        m_dac = 4'h0;
        m_adc = 4'h0;
      end
      `ADDR_POWERUP:
      begin
        m_led = 4'h0;
        m_adc = 4'h0;
      end
      default:
      begin
      end
    endcase
  endtask

  ////////////////////////////////////////
  // spi host

  // mode 0, msb first, miso taken at each sclk rise
  task automatic spi_xfer(input logic [7:0] addr, input logic [7:0] value,
                          input int nbits, output logic [7:0] rd);
    logic [31:0] word;
    int          i;
    word = {addr, value, 16'h0000};
    rd   = 8'h00;
    cs_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      mosi = word[31-i];
      repeat (HALF_SCLK) @(negedge clk);
      // peripherals see the host clock and data unchanged
      check_eq("periph_mosi", 8'(periph_mosi), 8'(word[31-i]));
      check_eq("periph_sclk", 8'(periph_sclk), 8'h00);
      // second byte carries the readback
      if (i >= 8 && i < 16)
        rd = {rd[6:0], miso};
      sclk = 1'b1;
      repeat (HALF_SCLK) @(negedge clk);
      check_eq("periph_sclk", 8'(periph_sclk), 8'h01);
      sclk = 1'b0;
    end
    repeat (HALF_SCLK) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (SETTLE) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // checks

  task automatic check_outputs();
    check_eq("led", 8'(led), {4'h0, m_led});
    check_eq("dac_ctrl", 8'(dac_ctrl), {4'h0, m_dac});
    check_eq("adc_ctrl", 8'(adc_ctrl), {4'h0, m_adc});
    // cs2_n high, switch idle
    check_eq("periph_cs_n", periph_cs_n, 8'hff);
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [7:0] value);
    logic [7:0] exp_rd;
    logic [7:0] rd;
    exp_rd = model_readback(addr);
    spi_xfer(addr, value, 16, rd);
    check_eq("miso readback", rd, exp_rd);
    model_commit(addr, value);
    check_outputs();
  endtask

  // cs2_n low, selects and miso follow the peripheral
  task automatic check_passthrough();
    logic [31:0] r;
    logic        exp_miso;
    int          n;
    int          k;
    cs2_n = 1'b0;
    for (n = 0; n < 4; n++)
    begin
      r           = $random(seed);
      periph_miso = r[7:0];
      exp_miso    = 1'b0;
      for (k = 0; k < 8; k++)
        if (m_mux[k])
          exp_miso = r[k];
      @(posedge clk);
      check_eq("periph_cs_n", periph_cs_n, ~m_mux);
      check_eq("miso", 8'(miso), 8'(exp_miso));
      @(negedge clk);
    end
    cs2_n       = 1'b1;
    periph_miso = 8'h00;
    @(posedge clk);
    check_eq("periph_cs_n", periph_cs_n, 8'hff);
    @(negedge clk);
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] r;
    logic [7:0]  addr;
    logic [7:0]  value;
    logic [7:0]  rd;
    int          i;
    int          pick;
    rst_n       = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = 8'h00;
    m_led       = 4'h0;
    m_mux       = 8'h00;
    m_dac       = `DAC_RESET_VAL;
    m_adc       = 4'h0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // reset values
    check_outputs();
    check_eq("miso", 8'(miso), 8'h00);

    // random set/clear/toggle frames
    for (i = 0; i < 30; i++)
    begin
      r     = $random(seed);
      pick  = int'(r[15:0]) % 3;
      value = r[23:16];
      case (pick)
        0:       addr = `ADDR_LED;
        1:       addr = `ADDR_DAC;
        default: addr = `ADDR_ADC;
      endcase
      // force a set/clear overlap now and then
      if (i % 3 == 0)
      begin
        value[0] = 1'b1;
        value[4] = 1'b1;
      end
      write_frame(addr, value);
    end

    // unmapped address is ignored
    write_frame(8'd3, 8'hff);

    // one-hot select, including none
    for (i = 0; i <= 10; i++)
    begin
      write_frame(`ADDR_SPI_MUX, 8'(i));
      check_passthrough();
    end

    // short and long frames
    // bits are chosen so the last 16 shifted in read as a led toggle,
    // any commit of them would show on led
    for (i = 0; i < 2; i++)
    begin
      // no-op write leaves a zero nibble ahead of the short frame
      write_frame(`ADDR_DAC, 8'h00);
      // 12 bits, shifted word reads 0x07ff
      spi_xfer(8'h7f, 8'hf0, 12, rd);
      check_outputs();
      // 18 bits, shifted word reads 0x07cc
      spi_xfer(8'h01, 8'hf3, 18, rd);
      check_outputs();
    end

    // power-up then soft reset
    write_frame(`ADDR_LED, 8'h0f);
    write_frame(`ADDR_DAC, 8'h05);
    write_frame(`ADDR_ADC, 8'h0a);
    write_frame(`ADDR_SPI_MUX, 8'd3);
    write_frame(`ADDR_POWERUP, 8'h00);
    check_passthrough();
    write_frame(`ADDR_SOFT_RST, 8'h00);
    check_passthrough();

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
panel_pkg.sv
spi_frame_fsm.sv
spi_bit_counter.sv
spi_shifter.sv
ctrl_reg_bank.sv
periph_spi_mux.sv
panel_top.sv
tb_panel_top.sv

//--- run_sim.sh
#!/bin/sh
# build the panel testbench with Verilator, run it, then check the log
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_panel_top \
  -f files.f -o sim_panel \
  && ./obj_dir/sim_panel > sim.log 2>&1 \
  || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
